// File: rtl/halfband_defs.svh
// Widths and sizes for the half-band decimator, included by both packages and by the RTL
`ifndef HALFBAND_DEFS_SVH
`define HALFBAND_DEFS_SVH

`default_nettype none

// Sample path widths
`define HB_DATA_W 20  // Input and output samples
`define HB_SUM_W 21  // Symmetric pair sums, one bit of growth
`define HB_PROD_W 22  // Shifted partial terms and the saturated result
`define HB_ACC_W 23  // Last two partial sums before saturation

// Stream layout
`define HB_STREAMS 4  // Interleaved streams per gate sequence

// Filter structure
// Eleven taps need ten delay sections, since d0 is the live input
`define HB_SECTIONS 10

`default_nettype wire

`endif

// File: rtl/dsp_pkg.sv
// Signed arithmetic types for the filter datapath, imported wherever samples or sums are held
`include "halfband_defs.svh"
`default_nettype none

package dsp_pkg;

	// Sample as carried between stages
	typedef logic signed [`HB_DATA_W-1:0] sample_t;

	// Intermediate values, one type per adder level
	typedef logic signed [`HB_SUM_W-1:0] pair_sum_t;  // Level one
	typedef logic signed [`HB_PROD_W-1:0] term_t;  // Level two and the saturated sum
	typedef logic signed [`HB_ACC_W-1:0] acc_t;  // Level three

	// Clamp limits of the saturated result
	localparam term_t term_max = {1'b0, {(`HB_PROD_W-1){1'b1}}};
	localparam term_t term_min = {1'b1, {(`HB_PROD_W-1){1'b0}}};

endpackage

`default_nettype wire

// File: rtl/stream_pkg.sv
// Gated stream beat and phase counter types, imported by the stage and the top level
`default_nettype none

package stream_pkg;

	import dsp_pkg::*;

	// One beat on a stream port
	// Consecutive gated beats walk through streams 0 .. len-1 and wrap
	typedef struct packed {
		logic gate;  // Sample valid this cycle
		sample_t data;  // Sample of the current stream
	} beat_t;

	// Position of a result within its group of streams
	typedef logic [8:0] phase_t;

endpackage

`default_nettype wire

// File: rtl/reg_delay.sv
// Gated delay line that returns the same stream's sample one round of interleaved samples later
`include "halfband_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module reg_delay #(
	parameter int len = `HB_STREAMS  // Positions, one per interleaved stream
) (
	input logic clk,
	input logic reset,
	input logic gate,  // Advance by one position
	input dsp_pkg::sample_t din,
	output dsp_pkg::sample_t dout
);

	import dsp_pkg::*;

	sample_t taps [0:len-1];  // taps[0] is the newest sample

	// Moves only on a gated sample, holds otherwise
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < len; i++) begin
				taps[i] <= '0;
			end
		end else if (gate) begin
			taps[0] <= din;
			for (int i = 1; i < len; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

	// After len gates the oldest entry belongs to the stream now at din
	assign dout = taps[len-1];

endmodule

`default_nettype wire

// File: rtl/sat_add.sv
// Registered adder of the last two partial sums, clamped to the narrower output width
`timescale 1ns/1ps
`default_nettype none

module sat_add (
	input logic clk,
	input logic reset,
	input dsp_pkg::acc_t a,
	input dsp_pkg::acc_t b,
	output dsp_pkg::term_t sum
);

	import dsp_pkg::*;

	localparam int in_w = $bits(acc_t);
	localparam int wide_w = in_w + 1;  // One guard bit keeps a + b exact
	localparam int out_w = $bits(term_t);

	logic signed [wide_w-1:0] wide;
	logic in_range;

	always_comb begin
		wide = wide_w'(a) + wide_w'(b);
		// Fits when every bit above the output sign matches that sign
		in_range = (wide[wide_w-1:out_w-1] == '0) || (wide[wide_w-1:out_w-1] == '1);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sum <= '0;
		end else if (in_range) begin
			sum <= term_t'(wide);  // Drop the redundant sign bits
		end else if (wide[wide_w-1]) begin
			sum <= term_min;  // Negative overflow
		end else begin
			sum <= term_max;  // Positive overflow
		end
	end

endmodule

`default_nettype wire

// File: rtl/half_filt.sv
// One half-band stage: 11-tap symmetric FIR on each interleaved stream, passing every other group
`include "halfband_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module half_filt #(
	parameter int len = `HB_STREAMS  // Number of interleaved streams
) (
	input logic clk,
	input logic reset,
	input stream_pkg::beat_t in_beat,
	output stream_pkg::beat_t out_beat
);

	import dsp_pkg::*;
	import stream_pkg::*;

	// d[k] is the same stream's sample k gated samples of that stream ago
	sample_t d [0:`HB_SECTIONS];

	assign d[0] = in_beat.data;

	genvar k;
	generate
		for (k = 0; k < `HB_SECTIONS; k++) begin : g_delay
			reg_delay #(
				.len(len)
			) i_delay (
				.clk(clk),
				.reset(reset),
				.gate(in_beat.gate),
				.din(d[k]),
				.dout(d[k+1])
			);
		end
	endgenerate

	// Coefficients, scaled by four at the output:
	// 2 * (1/32, 0, -1/8-1/64, 0, 1/2+1/8-1/64, 1, ... mirrored) / 4
	// Odd taps other than the centre are zero, so they never enter a sum

	pair_sum_t s1, s2, s3, s4;
	logic sg;

	// Level one folds the symmetric taps
	always_ff @(posedge clk) begin
		if (reset) begin
			s1 <= '0;
			s2 <= '0;
			s3 <= '0;
			s4 <= '0;
			sg <= 1'b0;
		end else begin
			s1 <= pair_sum_t'(d[0]) + pair_sum_t'(d[10]);
			s2 <= pair_sum_t'(d[2]) + pair_sum_t'(d[8]);
			s3 <= pair_sum_t'(d[4]) + pair_sum_t'(d[6]);
			s4 <= pair_sum_t'(d[5]);  // Centre tap
			sg <= in_beat.gate;
		end
	end

	term_t a1, a2, a3, a4;
	logic ag;

	// Level two applies the coefficients as shifts, truncating toward minus infinity
	always_ff @(posedge clk) begin
		if (reset) begin
			a1 <= '0;
			a2 <= '0;
			a3 <= '0;
			a4 <= '0;
			ag <= 1'b0;
		end else begin
			a1 <= term_t'(s1 >>> 4);
			a2 <= term_t'(s2 >>> 2) + term_t'(s2 >>> 5);
			a3 <= term_t'(s3 >>> 2) - term_t'(s3 >>> 5);
			a4 <= term_t'(s3) + (term_t'(s4) <<< 1);
			ag <= sg;
		end
	end

	acc_t b1, b2;
	logic bg;

	// Level three, the +1 is the fixed rounding offset
	always_ff @(posedge clk) begin
		if (reset) begin
			b1 <= '0;
			b2 <= '0;
			bg <= 1'b0;
		end else begin
			b1 <= acc_t'(a1) - acc_t'(a2);
			b2 <= acc_t'(a3) + acc_t'(a4) + acc_t'(1);
			bg <= ag;
		end
	end

	// Decimation: count results per group, show flips once per group
	phase_t phase;
	logic show;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= '0;
			show <= 1'b0;
		end else if (bg) begin
			if (phase == phase_t'(len - 1)) begin
				phase <= '0;
				show <= ~show;  // Group complete
			end else begin
				phase <= phase + 1'b1;
			end
		end
	end

	term_t c1;
	logic cg;

	sat_add i_sat_add (
		.clk(clk),
		.reset(reset),
		.a(b1),
		.b(b2),
		.sum(c1)
	);

	// Gate lines up with the registered saturated sum
	always_ff @(posedge clk) begin
		if (reset) begin
			cg <= 1'b0;
		end else begin
			cg <= bg & show;  // Show as it stood for this result
		end
	end

	// The two low bits undo the gain of four in the coefficients
	assign out_beat = '{gate: cg, data: c1[`HB_PROD_W-1:2]};

endmodule

`default_nettype wire

// File: rtl/decim_chain.sv
// Top level decimate-by-four for interleaved streams, two half-band stages in cascade
`include "halfband_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module decim_chain (
	input logic clk,
	input logic reset,
	input stream_pkg::beat_t in_beat,  // Full-rate interleaved samples
	output stream_pkg::beat_t out_beat  // One group in four per stream
);

	import stream_pkg::*;

	beat_t mid_beat;  // Half rate, same interleaving

	// Stage one, four cycles of latency
	half_filt #(
		.len(`HB_STREAMS)
	) i_stage1 (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.out_beat(mid_beat)
	);

	// Stage two, four more cycles
	half_filt #(
		.len(`HB_STREAMS)
	) i_stage2 (
		.clk(clk),
		.reset(reset),
		.in_beat(mid_beat),
		.out_beat(out_beat)
	);

endmodule

`default_nettype wire

// File: test/decim_chain_sva.sv
// Gate timing and reset assertions that the testbench binds to the decimator top level
`timescale 1ns/1ps
`default_nettype none

module decim_chain_sva (
	input logic clk,
	input logic reset,
	input stream_pkg::beat_t in_beat,
	input stream_pkg::beat_t mid_beat,
	input stream_pkg::beat_t out_beat
);

	int failures = 0;  // Assertion failures so far

	// Four register levels per stage mean a passed gate always has a gated input behind it
	a_stage1_latency: assert property (@(posedge clk) disable iff (reset)
		mid_beat.gate |-> $past(in_beat.gate, 4))
		else begin
			$error("stage one output gate without an input gate four cycles earlier");
			failures++;
		end

	a_stage2_latency: assert property (@(posedge clk) disable iff (reset)
		out_beat.gate |-> $past(mid_beat.gate, 4))
		else begin
			$error("stage two output gate without an input gate four cycles earlier");
			failures++;
		end

	a_reset_quiet: assert property (@(posedge clk) reset |=> !mid_beat.gate && !out_beat.gate)
		else begin
			$error("output gate high after a reset cycle");
			failures++;
		end

	a_first_after_reset: assert property (@(posedge clk) $fell(reset) |=> !out_beat.gate)
		else begin
			$error("output gate high on the first cycle out of reset");
			failures++;
		end

endmodule

`default_nettype wire

// File: test/decim_checker.sv
// Reference model of the two-stage decimator that the testbench uses to check DUT output beats
`include "halfband_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module decim_checker (
	input logic clk,
	input logic reset,
	input stream_pkg::beat_t in_beat,
	input stream_pkg::beat_t out_beat,
	input logic test_end,  // One-cycle pulse once a test has drained
	input int test_id,
	output int pending,
	output int checked,
	output int errors,
	output int failed_tests
);

	localparam int streams = `HB_STREAMS;
	localparam int taps = `HB_SECTIONS + 1;
	localparam int clamp_hi = (1 << (`HB_PROD_W - 1)) - 1;
	localparam int clamp_lo = -(1 << (`HB_PROD_W - 1));
	localparam int impulse_stream = 1;

	int hist [0:1][0:streams-1][0:taps-1];  // Indexed by stage and stream with newest first
	int in_pos [0:1];  // Stream of the next gated input
	int phase [0:1];
	bit show [0:1];
	int expect_q [$];
	int out_pos = 0;
	int n_checked = 0;
	int n_errors = 0;
	int n_failed = 0;
	int test_ins = 0;
	int test_outs = 0;
	int test_errs = 0;
	int sat_hits = 0;  // Passed results clamped in either stage
	logic [streams-1:0] nonzero = '0;

	assign checked = n_checked;
	assign errors = n_errors;
	assign failed_tests = n_failed;

	// Feeds one gated sample into stage st and returns whether its result is passed on
	function automatic bit stage_step(input int st, input int x, output int y);
		int s;
		int s1, s2, s3, s4;
		int a1, a2, a3, a4;
		int acc;
		bit passed;
		s = in_pos[st];
		for (int k = taps - 1; k > 0; k--) begin
			hist[st][s][k] = hist[st][s][k-1];
		end
		hist[st][s][0] = x;
		in_pos[st] = (s + 1) % streams;
		s1 = hist[st][s][0] + hist[st][s][10];
		s2 = hist[st][s][2] + hist[st][s][8];
		s3 = hist[st][s][4] + hist[st][s][6];
		s4 = hist[st][s][5];
		a1 = s1 >>> 4;  // Signed shifts floor toward minus infinity
		a2 = (s2 >>> 2) + (s2 >>> 5);
		a3 = (s3 >>> 2) - (s3 >>> 5);
		a4 = s3 + 2 * s4;
		acc = (a1 - a2) + (a3 + a4 + 1);
		passed = show[st];  // Show as it stood before this result
		if (acc > clamp_hi || acc < clamp_lo) begin
			if (passed) begin
				sat_hits++;
			end
			acc = (acc > clamp_hi) ? clamp_hi : clamp_lo;
		end
		y = acc >>> 2;  // Output scale
		if (phase[st] == streams - 1) begin
			phase[st] = 0;
			show[st] = !show[st];
		end else begin
			phase[st]++;
		end
		return passed;
	endfunction

	task automatic clear_model();
		for (int st = 0; st < 2; st++) begin
			for (int s = 0; s < streams; s++) begin
				for (int k = 0; k < taps; k++) begin
					hist[st][s][k] = 0;
				end
			end
			in_pos[st] = 0;
			phase[st] = 0;
			show[st] = 1'b0;
		end
		expect_q.delete();  // Samples in flight are discarded
		out_pos = 0;
	endtask

	task automatic check_output(input int v);
		int stream;
		int e;
		stream = out_pos;
		out_pos = (out_pos + 1) % streams;
		test_outs++;
		n_checked++;
		if (v != 0) begin
			nonzero[stream] = 1'b1;
		end
		if (expect_q.size() == 0) begin
			$display("error %0t: stream %0d gave %0d with no output expected", $time, stream, v);
			n_errors++;
			test_errs++;
		end else begin
			e = expect_q.pop_front();
			if (e != v) begin
				$display("error %0t: stream %0d output %0d, expected %0d", $time, stream, v, e);
				n_errors++;
				test_errs++;
			end
		end
	endtask

	task automatic end_test();
		bit ok;
		ok = (test_errs == 0);
		if (expect_q.size() != 0) begin
			$display("test %0d: %0d outputs still expected but never came", test_id,
				expect_q.size());
			ok = 1'b0;
		end
		if (test_id == 1 && test_outs * 4 != test_ins) begin
			$display("test 1: %0d outputs for %0d inputs, not one in four", test_outs, test_ins);
			ok = 1'b0;
		end
		if (test_id == 3 && nonzero != (1 << impulse_stream)) begin
			$display("test 3: nonzero output on streams %b, only stream %0d should have any",
				nonzero, impulse_stream);
			ok = 1'b0;
		end
		if (test_id == 4 && sat_hits == 0) begin
			$display("test 4: no passed result reached the clamp limits");
			ok = 1'b0;
		end
		$display("test %0d %s: %0d in, %0d out, %0d mismatches", test_id,
			ok ? "passed" : "failed", test_ins, test_outs, test_errs);
		if (!ok) begin
			n_failed++;
		end
		test_ins = 0;
		test_outs = 0;
		test_errs = 0;
		sat_hits = 0;
		nonzero = '0;
		expect_q.delete();
	endtask

	always @(posedge clk) begin
		int y1;
		int y2;
		if (reset) begin
			clear_model();
		end else begin
			if (out_beat.gate) begin
				check_output(int'(out_beat.data));
			end
			if (in_beat.gate) begin
				test_ins++;
				if (stage_step(0, int'(in_beat.data), y1)) begin
					if (stage_step(1, y1, y2)) begin
						expect_q.push_back(y2);
					end
				end
			end
		end
		if (test_end) begin
			end_test();
		end
		pending <= expect_q.size();
	end

endmodule

`default_nettype wire

// File: test/decim_chain_tb.sv
// Simulation top that drives the decimator through its random test sequence and prints the status
`include "halfband_defs.svh"
`timescale 1ns/1ps
`default_nettype none

module decim_chain_tb;

	import dsp_pkg::*;
	import stream_pkg::*;

	localparam int streams = `HB_STREAMS;
	localparam int num_tests = 5;
	localparam int reset_cycles = 4;
	localparam int chain_latency = 8;  // Two stages of four cycles
	localparam int drain_cycles = 24;  // Limit on waiting for outputs still expected
	localparam int len_full = 256;
	localparam int len_sparse = 600;
	localparam int len_impulse = 160;
	localparam int len_sat = 400;
	localparam int len_restart = 200;  // Each side of the mid-run reset
	localparam int per_test = reset_cycles + chain_latency + drain_cycles + 3;
	localparam int cycle_limit = 2 * (len_full + len_sparse + len_impulse + len_sat
		+ 2 * len_restart + reset_cycles + num_tests * per_test);
	localparam int impulse_stream = 1;
	localparam sample_t sample_max = sample_t'((1 << (`HB_DATA_W - 1)) - 1);
	localparam sample_t sample_min = sample_t'(1 << (`HB_DATA_W - 1));

	logic clk = 1'b0;
	logic reset;
	beat_t in_beat;
	beat_t out_beat;
	logic test_end;
	int test_id;
	logic [31:0] rng;
	int cycles = 0;
	int pending;
	int checked;
	int errors;
	int failed_tests;

	always #2 clk = ~clk;  // 4 ns period

	decim_chain i_decim_chain (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.out_beat(out_beat)
	);

	decim_checker i_checker (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.out_beat(out_beat),
		.test_end(test_end),
		.test_id(test_id),
		.pending(pending),
		.checked(checked),
		.errors(errors),
		.failed_tests(failed_tests)
	);

	bind decim_chain decim_chain_sva i_sva (
		.clk(clk),
		.reset(reset),
		.in_beat(in_beat),
		.mid_beat(mid_beat),
		.out_beat(out_beat)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] v;
		v = x ^ (x << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic sample_t rand_sample();
		return sample_t'(next_rand());  // Low bits span the full sample range
	endfunction

	// Each task starts just after a rising edge and ends on one
	task automatic drive_sample(input logic valid, input sample_t value);
		in_beat <= '{gate: valid, data: value};
		@(posedge clk);
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		in_beat <= '0;
		repeat (reset_cycles) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic finish_test(input int id);
		int waited;
		in_beat <= '0;
		waited = 0;
		repeat (chain_latency) @(posedge clk);  // Last gated input reaches out_beat
		@(negedge clk);
		while (pending != 0 && waited < drain_cycles) begin
			@(negedge clk);
			waited++;
		end
		@(posedge clk);
		test_id <= id;
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
		@(posedge clk);
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles before the tests completed", cycles);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial begin
		logic [31:0] r;
		reset = 1'b1;
		in_beat = '0;
		test_end = 1'b0;
		test_id = 0;
		rng = 32'd26343;
		@(posedge clk);

		apply_reset();  // Full rate random
		repeat (len_full) drive_sample(1'b1, rand_sample());
		finish_test(1);

		apply_reset();  // Sparse gate about one cycle in four
		repeat (len_sparse) begin
			r = next_rand();
			drive_sample(r[27:26] == 2'b00, sample_t'(r));
		end
		finish_test(2);

		apply_reset();
		for (int g = 0; g < len_impulse / streams; g++) begin
			for (int s = 0; s < streams; s++) begin
				drive_sample(1'b1, (g == 2 && s == impulse_stream) ?
					sample_t'(1 << (`HB_DATA_W - 2)) : sample_t'(0));
			end
		end
		finish_test(3);

		apply_reset();  // Full-scale samples of random sign
		repeat (len_sat) begin
			r = next_rand();
			drive_sample(1'b1, r[5] ? sample_max : sample_min);
		end
		finish_test(4);

		apply_reset();
		repeat (len_restart) drive_sample(1'b1, rand_sample());
		reset <= 1'b1;  // Samples keep coming while reset is high
		repeat (reset_cycles) drive_sample(1'b1, rand_sample());
		reset <= 1'b0;
		repeat (len_restart) drive_sample(1'b1, rand_sample());
		finish_test(5);

		$display("%0d tests, %0d failed, %0d outputs checked, %0d errors, %0d assertion failures",
			num_tests, failed_tests, checked, errors, i_decim_chain.i_sva.failures);
		if (failed_tests == 0 && errors == 0 && i_decim_chain.i_sva.failures == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: halfband_decim.f
+incdir+rtl
rtl/dsp_pkg.sv
rtl/stream_pkg.sv
rtl/reg_delay.sv
rtl/sat_add.sv
rtl/half_filt.sv
rtl/decim_chain.sv
test/decim_chain_sva.sv
test/decim_checker.sv
test/decim_chain_tb.sv

// File: Makefile
# Verilator build and run of the half-band decimator testbench

VERILATOR ?= verilator
TOP ?= decim_chain_tb
FILELIST ?= halfband_decim.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= STATUS: PASS

SOURCES := $(FILELIST) $(wildcard rtl/*.sv rtl/*.svh test/*.sv)
BINARY := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(BINARY))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
